/* logic/cdb_arbiter.sv */
`default_nettype none

module cdb_arbiter import ooo_pkg::*; (
  input  wire             clk_100mhz,
  input  wire             sys_rst,
  input  wire fu_result_t i_mul,
  input  wire fu_result_t i_alu,
  output logic            o_alu_grant,
  output cdb_t            o_cdb
);

  logic cdb_valid;
  tag_t cdb_tag;
  word_t cdb_value;

  // multiplier cannot stall so it always goes first
  assign o_alu_grant = i_alu.valid && !i_mul.valid;
  assign o_cdb = '{valid: cdb_valid, tag: cdb_tag, value: cdb_value};

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= i_mul.valid || i_alu.valid;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_mul.valid) begin
      cdb_tag <= i_mul.tag;
      cdb_value <= i_mul.value;
    end else begin
      cdb_tag <= i_alu.tag;
      cdb_value <= i_alu.value;
    end
  end

endmodule

`default_nettype wire

/* logic/inst_decode.sv */
`default_nettype none

module inst_decode import ooo_pkg::*; (
  input  wire word_t i_inst,
  output decoded_t   o_dec
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  always_comb begin
    o_dec = '0;
    o_dec.rd = i_inst[11:7];
    o_dec.rs1 = i_inst[19:15];
    o_dec.rs2 = i_inst[24:20];
    o_dec.mul_func = mul_func_e'(funct3[1:0]);

    case (funct3)
      3'b000: begin
        if (opcode == OPC_OP && funct7[5]) o_dec.alu_func = ALU_SUB;
        else o_dec.alu_func = ALU_ADD;  // addi never subtracts
      end
      3'b001: o_dec.alu_func = ALU_SLL;
      3'b010: o_dec.alu_func = ALU_SLT;
      3'b011: o_dec.alu_func = ALU_SLTU;
      3'b100: o_dec.alu_func = ALU_XOR;
      3'b101: begin
        if (funct7[5]) o_dec.alu_func = ALU_SRA;
        else o_dec.alu_func = ALU_SRL;
      end
      3'b110: o_dec.alu_func = ALU_OR;
      default: o_dec.alu_func = ALU_AND;
    endcase

    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'b0000001) begin
          // divides have funct3[2] set and are dropped
          o_dec.cls = funct3[2] ? CLASS_NONE : CLASS_MUL;
        end else begin
          o_dec.cls = CLASS_ALU;
        end
      end
      OPC_OP_IMM: begin
        o_dec.cls = CLASS_ALU;
        o_dec.use_imm = 1'b1;
        o_dec.imm = {{20{i_inst[31]}}, i_inst[31:20]};  // i-type
      end
      OPC_LUI: begin
        o_dec.cls = CLASS_ALU;
        o_dec.alu_func = ALU_PASS_B;
        o_dec.use_imm = 1'b1;
        o_dec.imm = {i_inst[31:12], 12'b0};  // u-type
        o_dec.rs1 = '0;  // these bits belong to the immediate
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* logic/int_alu.sv */
`default_nettype none

module int_alu import ooo_pkg::*; (
  input  wire            clk_100mhz,
  input  wire            sys_rst,
  input  wire            i_en,
  input  wire alu_func_e i_func,
  input  wire word_t     i_a,
  input  wire word_t     i_b,
  input  wire tag_t      i_tag,
  input  wire            i_grant,
  output logic           o_ready,
  output fu_result_t     o_result
);

  word_t result;
  logic res_valid;
  tag_t res_tag;
  word_t res_value;

  always_comb begin
    case (i_func)
      ALU_ADD:    result = i_a + i_b;
      ALU_SUB:    result = i_a - i_b;
      ALU_SLL:    result = i_a << i_b[4:0];
      ALU_SLT:    result = {31'b0, $signed(i_a) < $signed(i_b)};
      ALU_SLTU:   result = {31'b0, i_a < i_b};
      ALU_XOR:    result = i_a ^ i_b;
      ALU_SRL:    result = i_a >> i_b[4:0];
      ALU_SRA:    result = $signed(i_a) >>> i_b[4:0];
      ALU_OR:     result = i_a | i_b;
      ALU_AND:    result = i_a & i_b;
      ALU_PASS_B: result = i_b;
      default:    result = '0;
    endcase
  end

  // a held result frees up on the cycle it is granted
  assign o_ready = !res_valid || i_grant;
  assign o_result = '{valid: res_valid, tag: res_tag, value: res_value};

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      res_valid <= 1'b0;
    end else if (i_en) begin
      res_valid <= 1'b1;
    end else if (i_grant) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_en) begin
      res_tag <= i_tag;
      res_value <= result;
    end
  end

endmodule

`default_nettype wire

/* logic/ooo_core.sv */
`default_nettype none

module ooo_core import ooo_pkg::*; #(
  parameter int ROB_DEPTH = 8,
  parameter int RS_DEPTH  = 3
) (
  input  wire        clk_100mhz,
  input  wire        sys_rst,
  input  wire        i_inst_valid,
  input  wire word_t i_inst,
  output logic       o_inst_ready,
  output logic       o_commit_valid,
  output reg_addr_t  o_commit_rd,
  output word_t      o_commit_value
);

  decoded_t dec;
  operand_t rf_src1, rf_src2;
  operand_t fwd1, fwd2;
  operand_t src1, src2;
  cdb_t cdb;
  fu_result_t alu_res, mul_res;
  tag_t alloc_tag, commit_tag;
  logic rob_full, rs_alu_full, rs_mul_full;
  logic accept, alu_issue, mul_issue, alloc_en;

  logic alu_disp_en, alu_ready, alu_grant;
  alu_func_e alu_disp_func;
  word_t alu_a, alu_b;
  tag_t alu_tag;
  logic mul_disp_en;
  mul_func_e mul_disp_func;
  word_t mul_a, mul_b;
  tag_t mul_tag;

  inst_decode decode_i (.i_inst(i_inst), .o_dec(dec));

  // none-class words only need the rob to have room
  always_comb begin
    case (dec.cls)
      CLASS_ALU: o_inst_ready = !rob_full && !rs_alu_full;
      CLASS_MUL: o_inst_ready = !rob_full && !rs_mul_full;
      default:   o_inst_ready = !rob_full;
    endcase
  end

  assign accept = i_inst_valid && o_inst_ready;
  assign alu_issue = accept && (dec.cls == CLASS_ALU);
  assign mul_issue = accept && (dec.cls == CLASS_MUL);
  assign alloc_en = alu_issue || mul_issue;

  // register first, then rob, imm overrides rs2
  always_comb begin
    src1 = rf_src1.ready ? rf_src1 : fwd1;
    if (dec.use_imm) begin
      src2 = '{ready: 1'b1, tag: '0, value: dec.imm};
    end else begin
      src2 = rf_src2.ready ? rf_src2 : fwd2;
    end
  end

  rename_reg_file rf_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_rs1(dec.rs1), .i_rs2(dec.rs2),
    .i_rename_en(alloc_en), .i_rename_rd(dec.rd), .i_rename_tag(alloc_tag),
    .i_commit_en(o_commit_valid), .i_commit_rd(o_commit_rd),
    .i_commit_tag(commit_tag), .i_commit_value(o_commit_value),
    .o_src1(rf_src1), .o_src2(rf_src2)
  );

  reorder_buffer #(.DEPTH(ROB_DEPTH)) rob_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_alloc_en(alloc_en), .i_alloc_rd(dec.rd),
    .o_alloc_tag(alloc_tag), .o_full(rob_full), .i_cdb(cdb),
    .i_fwd1_tag(rf_src1.tag), .i_fwd2_tag(rf_src2.tag),
    .o_fwd1(fwd1), .o_fwd2(fwd2),
    .o_commit_en(o_commit_valid), .o_commit_rd(o_commit_rd),
    .o_commit_tag(commit_tag), .o_commit_value(o_commit_value)
  );

  reservation_station #(.DEPTH(RS_DEPTH), .payload_t(alu_func_e)) rs_alu_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_issue_en(alu_issue), .i_payload(dec.alu_func),
    .i_src1(src1), .i_src2(src2), .i_tag(alloc_tag), .o_full(rs_alu_full),
    .i_cdb(cdb), .i_fu_ready(alu_ready),
    .o_disp_en(alu_disp_en), .o_disp_payload(alu_disp_func),
    .o_disp_a(alu_a), .o_disp_b(alu_b), .o_disp_tag(alu_tag)
  );

  reservation_station #(.DEPTH(RS_DEPTH), .payload_t(mul_func_e)) rs_mul_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_issue_en(mul_issue), .i_payload(dec.mul_func),
    .i_src1(src1), .i_src2(src2), .i_tag(alloc_tag), .o_full(rs_mul_full),
    .i_cdb(cdb), .i_fu_ready(1'b1),  // fully pipelined
    .o_disp_en(mul_disp_en), .o_disp_payload(mul_disp_func),
    .o_disp_a(mul_a), .o_disp_b(mul_b), .o_disp_tag(mul_tag)
  );

  int_alu alu_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_en(alu_disp_en), .i_func(alu_disp_func), .i_a(alu_a), .i_b(alu_b),
    .i_tag(alu_tag), .i_grant(alu_grant), .o_ready(alu_ready), .o_result(alu_res)
  );

  pipe_multiplier mul_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_en(mul_disp_en), .i_func(mul_disp_func), .i_a(mul_a), .i_b(mul_b),
    .i_tag(mul_tag), .o_result(mul_res)
  );

  cdb_arbiter arb_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_mul(mul_res), .i_alu(alu_res), .o_alu_grant(alu_grant), .o_cdb(cdb)
  );

endmodule

`default_nettype wire

/* logic/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

  localparam int TAG_W = 4;  // covers a rob of up to 16 entries

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [TAG_W-1:0] tag_t;

  typedef enum logic [1:0] {
    CLASS_NONE = 2'd0,  // accepted and dropped
    CLASS_ALU  = 2'd1,
    CLASS_MUL  = 2'd2
  } inst_class_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // lui
  } alu_func_e;

  // same order as funct3[1:0]
  typedef enum logic [1:0] {
    MUL_MUL,
    MUL_MULH,
    MUL_MULHSU,
    MUL_MULHU
  } mul_func_e;

  typedef struct packed {
    inst_class_e cls;
    alu_func_e   alu_func;
    mul_func_e   mul_func;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic        use_imm;  // operand b is the immediate
    word_t       imm;
  } decoded_t;

  typedef struct packed {
    logic  ready;
    tag_t  tag;  // producer while not ready
    word_t value;
  } operand_t;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    word_t value;
  } cdb_t;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    word_t value;
  } fu_result_t;

endpackage

`default_nettype wire

/* logic/pipe_multiplier.sv */
`default_nettype none

module pipe_multiplier import ooo_pkg::*; (
  input  wire            clk_100mhz,
  input  wire            sys_rst,
  input  wire            i_en,
  input  wire mul_func_e i_func,
  input  wire word_t     i_a,
  input  wire word_t     i_b,
  input  wire tag_t      i_tag,
  output fu_result_t     o_result
);

  logic [2:0] vld;  // one per stage
  tag_t tag_s1;
  tag_t tag_s2;
  tag_t tag_s3;
  mul_func_e func_s1;
  mul_func_e func_s2;
  logic signed [32:0] a_s1;
  logic signed [32:0] b_s1;
  logic signed [65:0] prod_s2;
  word_t value_s3;

  assign o_result = '{valid: vld[2], tag: tag_s3, value: value_s3};

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      vld <= '0;
    end else begin
      vld <= {vld[1:0], i_en};
    end
  end

  always_ff @(posedge clk_100mhz) begin
    // stage 1 extends each operand by its signedness
    a_s1 <= {(i_func != MUL_MULHU) & i_a[31], i_a};
    b_s1 <= {(i_func == MUL_MUL || i_func == MUL_MULH) & i_b[31], i_b};
    tag_s1 <= i_tag;
    func_s1 <= i_func;
    // stage 2
    prod_s2 <= a_s1 * b_s1;
    tag_s2 <= tag_s1;
    func_s2 <= func_s1;
    // stage 3 keeps the low word for mul and the high word otherwise
    value_s3 <= (func_s2 == MUL_MUL) ? prod_s2[31:0] : prod_s2[63:32];
    tag_s3 <= tag_s2;
  end

endmodule

`default_nettype wire

/* logic/rename_reg_file.sv */
`default_nettype none

module rename_reg_file import ooo_pkg::*; (
  input  wire            clk_100mhz,
  input  wire            sys_rst,
  input  wire reg_addr_t i_rs1,
  input  wire reg_addr_t i_rs2,
  input  wire            i_rename_en,
  input  wire reg_addr_t i_rename_rd,
  input  wire tag_t      i_rename_tag,
  input  wire            i_commit_en,
  input  wire reg_addr_t i_commit_rd,
  input  wire tag_t      i_commit_tag,
  input  wire word_t     i_commit_value,
  output operand_t       o_src1,
  output operand_t       o_src2
);

  word_t regs [32];
  tag_t tags [32];  // youngest in-flight producer
  logic [31:0] busy;

  // x0 is never written or renamed so it reads as ready zero
  assign o_src1 = '{ready: !busy[i_rs1], tag: tags[i_rs1], value: regs[i_rs1]};
  assign o_src2 = '{ready: !busy[i_rs2], tag: tags[i_rs2], value: regs[i_rs2]};

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy <= '0;
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (i_commit_en && i_commit_rd != '0) begin
        regs[i_commit_rd] <= i_commit_value;
        if (tags[i_commit_rd] == i_commit_tag) begin
          busy[i_commit_rd] <= 1'b0;  // no younger writer pending
        end
      end
      if (i_rename_en && i_rename_rd != '0) begin
        busy[i_rename_rd] <= 1'b1;  // overrides a same-cycle commit
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_rename_en && i_rename_rd != '0) begin
      tags[i_rename_rd] <= i_rename_tag;
    end
  end

endmodule

`default_nettype wire

/* logic/reorder_buffer.sv */
`default_nettype none

module reorder_buffer import ooo_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  wire            clk_100mhz,
  input  wire            sys_rst,
  input  wire            i_alloc_en,
  input  wire reg_addr_t i_alloc_rd,
  output tag_t           o_alloc_tag,
  output logic           o_full,
  input  wire cdb_t      i_cdb,
  input  wire tag_t      i_fwd1_tag,
  input  wire tag_t      i_fwd2_tag,
  output operand_t       o_fwd1,
  output operand_t       o_fwd2,
  output logic           o_commit_en,
  output reg_addr_t      o_commit_rd,
  output tag_t           o_commit_tag,
  output word_t          o_commit_value
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W:0] count;
  logic [DEPTH-1:0] done;
  reg_addr_t rd_q [DEPTH];
  word_t value_q [DEPTH];
  logic [PTR_W-1:0] cdb_idx;

  // done entry, or its result on the cdb right now
  function automatic operand_t lookup(tag_t t);
    operand_t op;
    op.tag = t;
    if (i_cdb.valid && i_cdb.tag == t) begin
      op.ready = 1'b1;
      op.value = i_cdb.value;
    end else begin
      op.ready = done[t[PTR_W-1:0]];
      op.value = value_q[t[PTR_W-1:0]];
    end
    return op;
  endfunction

  always_comb begin
    o_fwd1 = lookup(i_fwd1_tag);
    o_fwd2 = lookup(i_fwd2_tag);
  end

  assign cdb_idx = i_cdb.tag[PTR_W-1:0];
  assign o_full = (count == DEPTH);
  assign o_alloc_tag = tag_t'(tail);

  assign o_commit_en = (count != '0) && done[head];
  assign o_commit_rd = rd_q[head];
  assign o_commit_tag = tag_t'(head);
  assign o_commit_value = (rd_q[head] == '0) ? '0 : value_q[head];  // x0 reads zero

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      done <= '0;
    end else begin
      if (i_alloc_en) begin
        tail <= tail + 1'b1;
        done[tail] <= 1'b0;
      end
      if (i_cdb.valid) begin
        done[cdb_idx] <= 1'b1;
      end
      if (o_commit_en) begin
        head <= head + 1'b1;  // retire in order
      end
      count <= count + (PTR_W+1)'(i_alloc_en) - (PTR_W+1)'(o_commit_en);
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_alloc_en) begin
      rd_q[tail] <= i_alloc_rd;
    end
    if (i_cdb.valid) begin
      value_q[cdb_idx] <= i_cdb.value;
    end
  end

endmodule

`default_nettype wire

/* logic/reservation_station.sv */
`default_nettype none

module reservation_station import ooo_pkg::*; #(
  parameter int DEPTH = 3,
  parameter type payload_t = alu_func_e
) (
  input  wire           clk_100mhz,
  input  wire           sys_rst,
  input  wire           i_issue_en,
  input  wire payload_t i_payload,
  input  wire operand_t i_src1,
  input  wire operand_t i_src2,
  input  wire tag_t     i_tag,
  output logic          o_full,
  input  wire cdb_t     i_cdb,
  input  wire           i_fu_ready,
  output logic          o_disp_en,
  output payload_t      o_disp_payload,
  output word_t         o_disp_a,
  output word_t         o_disp_b,
  output tag_t          o_disp_tag
);

  localparam int AGE_W = $clog2(DEPTH + 1);
  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef struct packed {
    payload_t payload;
    operand_t src1;
    operand_t src2;
    tag_t     tag;
  } entry_t;

  logic [DEPTH-1:0] valid;
  entry_t ent [DEPTH];
  logic [AGE_W-1:0] age [DEPTH];  // number of older entries
  logic any_rdy;
  logic have_free;
  logic [IDX_W-1:0] disp_idx;
  logic [IDX_W-1:0] free_idx;
  logic [AGE_W-1:0] n_valid;

  function automatic operand_t snoop(operand_t op, cdb_t cdb);
    operand_t res;
    res = op;
    if (!op.ready && cdb.valid && cdb.tag == op.tag) begin
      res.ready = 1'b1;
      res.value = cdb.value;
    end
    return res;
  endfunction

  // oldest ready entry, first free slot
  always_comb begin
    any_rdy = 1'b0;
    have_free = 1'b0;
    disp_idx = '0;
    free_idx = '0;
    n_valid = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (valid[i] && ent[i].src1.ready && ent[i].src2.ready &&
          (!any_rdy || age[i] < age[disp_idx])) begin
        any_rdy = 1'b1;
        disp_idx = IDX_W'(i);
      end
      if (!valid[i] && !have_free) begin
        have_free = 1'b1;
        free_idx = IDX_W'(i);
      end
      n_valid = n_valid + AGE_W'(valid[i]);
    end
  end

  assign o_full = !have_free;
  assign o_disp_en = any_rdy && i_fu_ready;
  assign o_disp_payload = ent[disp_idx].payload;
  assign o_disp_a = ent[disp_idx].src1.value;
  assign o_disp_b = ent[disp_idx].src2.value;
  assign o_disp_tag = ent[disp_idx].tag;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      valid <= '0;
    end else begin
      if (o_disp_en) valid[disp_idx] <= 1'b0;
      if (i_issue_en) valid[free_idx] <= 1'b1;  // free slot never the dispatched one
    end
  end

  always_ff @(posedge clk_100mhz) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (valid[i]) begin
        ent[i].src1 <= snoop(ent[i].src1, i_cdb);
        ent[i].src2 <= snoop(ent[i].src2, i_cdb);
        if (o_disp_en && age[i] > age[disp_idx]) begin
          age[i] <= age[i] - 1'b1;  // one fewer older entry
        end
      end
    end
    if (i_issue_en) begin
      ent[free_idx] <= '{payload: i_payload, src1: i_src1, src2: i_src2, tag: i_tag};
      age[free_idx] <= n_valid - AGE_W'(o_disp_en);
    end
  end

endmodule

`default_nettype wire

/* ooo_core.f */
logic/ooo_pkg.sv
logic/inst_decode.sv
logic/rename_reg_file.sv
logic/reorder_buffer.sv
logic/reservation_station.sv
logic/int_alu.sv
logic/pipe_multiplier.sv
logic/cdb_arbiter.sv
logic/ooo_core.sv
sim/ooo_core_tb.sv

/* sim/ooo_core_stim.txt */
// columns: test, instruction word, commit flag, rd, expected value (all hex)
// commit flag 0 marks a word that is discarded, rd 1f is only a filler there
2 00500093 1 01 00000005  // addi x1, x0, 5
2 ffd00113 1 02 fffffffd  // addi x2, x0, -3
2 123451b7 1 03 12345000  // lui x3, 0x12345
2 00208233 1 04 00000002  // add x4, x1, x2
2 00700013 1 00 00000000  // addi x0, x0, 7
2 0ff04293 1 05 000000ff  // xori x5, x0, 0xff
3 00a00313 1 06 0000000a  // addi x6, x0, 10
3 00431393 1 07 000000a0  // slli x7, x6, 4
3 40638433 1 08 00000096  // sub x8, x7, x6
3 00130313 1 06 0000000b  // addi x6, x6, 1
3 40115493 1 09 fffffffe  // srai x9, x2, 1
3 0084a533 1 0a 00000001  // slt x10, x9, x8
3 0084b5b3 1 0b 00000000  // sltu x11, x9, x8
3 00a46633 1 0c 00000097  // or x12, x8, x10
3 007676b3 1 0d 00000080  // and x13, x12, x7
4 80000737 1 0e 80000000  // lui x14, 0x80000
4 027407b3 1 0f 00005dc0  // mul x15, x8, x7
4 02971833 1 10 00000001  // mulh x16, x14, x9
4 00300893 1 11 00000003  // addi x17, x0, 3
4 02e4a933 1 12 ffffffff  // mulhsu x18, x9, x14
4 02e4b9b3 1 13 7fffffff  // mulhu x19, x9, x14
4 01178a33 1 14 00005dc3  // add x20, x15, x17
4 01284ab3 1 15 fffffffe  // xor x21, x16, x18
5 00100b13 1 16 00000001  // addi x22, x0, 1
5 00300b93 1 17 00000003  // addi x23, x0, 3
5 037b0b33 1 16 00000003  // mul x22, x22, x23 from here on
5 037b0b33 1 16 00000009
5 037b0b33 1 16 0000001b
5 037b0b33 1 16 00000051
5 037b0b33 1 16 000000f3
5 037b0b33 1 16 000002d9
5 037b0b33 1 16 0000088b
5 037b0b33 1 16 000019a1
5 037b0b33 1 16 00004ce3
5 037b0b33 1 16 0000e6a9
5 01100c13 1 18 00000011  // addi x24, x0, 0x11
5 02200c93 1 19 00000022  // addi x25, x0, 0x22
5 03300d13 1 1a 00000033  // addi x26, x0, 0x33
6 00112023 0 1f 00000000  // sw x1, 0(x2)
6 00000463 0 1f 00000000  // beq x0, x0, 8
6 0220cdb3 0 1f 00000000  // div x27, x1, x2
6 001d8e13 1 1c 00000001  // addi x28, x27, 1
6 01308eb3 1 1d 80000004  // add x29, x1, x19

/* sim/ooo_core_tb.sv */
`default_nettype none

module ooo_core_tb import ooo_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_LINES = 64;
  localparam int MAX_TESTS = 8;
  localparam int BURST_TEST = 5;  // driven back to back
  localparam int IDLE_CYCLES = 8;
  localparam int DRAIN_CYCLES = 20;

  logic clk_100mhz;
  logic sys_rst;
  logic i_inst_valid;
  word_t i_inst;
  logic o_inst_ready;
  logic o_commit_valid;
  reg_addr_t o_commit_rd;
  word_t o_commit_value;

  logic [31:0] stim_mem [5*MAX_LINES];  // five columns per line
  int n_lines;
  int n_exp;
  int exp_idx;
  int exp_test [MAX_LINES];
  logic [31:0] exp_rd [MAX_LINES];
  logic [31:0] exp_val [MAX_LINES];
  int last_exp [MAX_TESTS];  // index of a test's final commit
  int test_checks [MAX_TESTS];
  int test_errs [MAX_TESTS];
  int n_checks;
  int n_errors;
  int tests_run;
  int tests_failed;
  int cycle_cnt;
  int cycle_limit;

  ooo_core dut_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_inst_valid(i_inst_valid), .i_inst(i_inst), .o_inst_ready(o_inst_ready),
    .o_commit_valid(o_commit_valid), .o_commit_rd(o_commit_rd),
    .o_commit_value(o_commit_value)
  );

  always #5 clk_100mhz = ~clk_100mhz;

  function automatic string test_name(int t);
    case (t)
      1: return "idle after reset";
      2: return "independent alu ops";
      3: return "dependent alu chain";
      4: return "multiplies";
      5: return "multiply burst";
      6: return "discarded words";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_value(input int t, input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    n_checks++;
    test_checks[t]++;
    if (expected !== actual) begin
      n_errors++;
      test_errs[t]++;
      $display("[FAIL] %s %s: expected %h, actual %h", test_name(t), what, expected, actual);
    end
  endtask

  task automatic report_test(input int t);
    tests_run++;
    if (test_errs[t] != 0) tests_failed++;
    $display("test %0d %s: %0d checks, %0d errors", t, test_name(t), test_checks[t],
             test_errs[t]);
  endtask

  task automatic load_stimulus();
    int t;
    $readmemh("sim/ooo_core_stim.txt", stim_mem);
    n_lines = 0;
    n_exp = 0;
    while (n_lines < MAX_LINES && !$isunknown(stim_mem[5*n_lines])) begin
      t = stim_mem[5*n_lines];
      if (stim_mem[5*n_lines+2] != 0) begin
        exp_test[n_exp] = t;
        exp_rd[n_exp] = stim_mem[5*n_lines+3];
        exp_val[n_exp] = stim_mem[5*n_lines+4];
        last_exp[t] = n_exp;
        n_exp++;
      end
      n_lines++;
    end
  endtask

  // checks each commit against the next expected entry
  always @(posedge clk_100mhz) begin
    if (!sys_rst && o_commit_valid) begin
      if (exp_idx >= n_exp) begin
        n_errors++;
        $display("commit to x%0d arrived with no expected commit left", o_commit_rd);
      end else begin
        check_value(exp_test[exp_idx], "rd", exp_rd[exp_idx], 32'(o_commit_rd));
        check_value(exp_test[exp_idx], "value", exp_val[exp_idx], o_commit_value);
        if (last_exp[exp_test[exp_idx]] == exp_idx) report_test(exp_test[exp_idx]);
        exp_idx++;
      end
    end
  end

  always @(posedge clk_100mhz) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    int gap;
    int stalls;
    int t;
    clk_100mhz = 1'b0;
    sys_rst = 1'b1;
    i_inst_valid = 1'b0;
    i_inst = '0;
    exp_idx = 0;
    n_checks = 0;
    n_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    cycle_cnt = 0;
    stalls = 0;
    for (int k = 0; k < MAX_TESTS; k++) begin
      last_exp[k] = -1;
      test_checks[k] = 0;
      test_errs[k] = 0;
    end
    void'($urandom(81265));
    load_stimulus();
    cycle_limit = 40 * n_lines + 60;  // plus reset, idle and drain
    if (n_lines == 0) begin
      n_errors++;
      $display("no stimulus lines could be read from sim/ooo_core_stim.txt");
    end

    repeat (3) @(posedge clk_100mhz);
    sys_rst <= 1'b0;

    repeat (IDLE_CYCLES) begin
      @(posedge clk_100mhz);
      check_value(1, "commit valid", 32'd0, 32'(o_commit_valid));
      check_value(1, "inst ready", 32'd1, 32'(o_inst_ready));
    end
    report_test(1);

    for (int i = 0; i < n_lines; i++) begin
      t = stim_mem[5*i];
      gap = (t == BURST_TEST) ? 0 : int'($urandom % 3);
      if (gap != 0) begin
        i_inst_valid <= 1'b0;
        repeat (gap) @(posedge clk_100mhz);
      end
      i_inst_valid <= 1'b1;
      i_inst <= stim_mem[5*i+1];
      @(posedge clk_100mhz);
      while (!o_inst_ready) begin  // hold the word
        if (t == BURST_TEST) stalls++;
        @(posedge clk_100mhz);
      end
      if (t == BURST_TEST && (i + 1 == n_lines || stim_mem[5*(i+1)] != BURST_TEST)) begin
        check_value(BURST_TEST, "ready stalls seen", 32'd1, 32'(stalls != 0));
      end
    end
    i_inst_valid <= 1'b0;

    while (exp_idx < n_exp) @(posedge clk_100mhz);
    repeat (DRAIN_CYCLES) @(posedge clk_100mhz);  // stray commits show up here

    $display("%0d tests run, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
             n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
